//--- build.f
t05_pkg.sv
t05_bytecount.sv
t05_histogram.sv
t05_find_least.sv
t05_wishbone_manager.sv
t05_controller.sv
t05_top.sv
t05_wb_memory.sv
t05_tb.sv

//--- t05_tb.sv
module t05_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam t05_pkg::wb_addr_t HIST_BASE = 32'h3300_0000;
  localparam logic [31:0] RNG_SEED = 32'h5360c4fc;
  localparam int NUM_RUNS = 4;
  localparam int HALF_PERIOD = 20;

  logic                 hwclk;
  logic                 rst_n_i;
  logic                 start_i;
  logic                 chunk_pulse_i;
  t05_pkg::chunk_t      chunk_i;
  logic                 char_ready_o;
  logic                 done_o;
  t05_pkg::count_t      total_o;
  t05_pkg::flv_result_t result_o;
  logic                 wbs_cyc;
  logic                 wbs_stb;
  logic                 wbs_we;
  logic [3:0]           wbs_sel;
  t05_pkg::wb_addr_t    wbs_adr;
  t05_pkg::count_t      wbs_dat_w;
  t05_pkg::count_t      wbs_dat_r;
  logic                 wbs_ack;

  // every run is a slice of chunk_mem
  t05_pkg::chunk_t      chunk_mem[$];
  t05_pkg::char_t       char_q[$];
  int                   run_first [NUM_RUNS];
  int                   run_len [NUM_RUNS];
  logic [31:0]          rng;
  logic                 streams_ready;

  // expected values of the run in progress
  t05_pkg::count_t      exp_count [256];
  t05_pkg::count_t      exp_total;
  t05_pkg::flv_result_t exp_result;
  int                   n_drive;

  int                   checks;
  int                   errors;
  int                   runs_checked;

  t05_top #(.HIST_BASE(HIST_BASE)) DUT (
    .hwclk        (hwclk),
    .rst_n_i      (rst_n_i),
    .start_i      (start_i),
    .chunk_pulse_i(chunk_pulse_i),
    .chunk_i      (chunk_i),
    .char_ready_o (char_ready_o),
    .done_o       (done_o),
    .total_o      (total_o),
    .result_o     (result_o),
    .wbs_cyc_o    (wbs_cyc),
    .wbs_stb_o    (wbs_stb),
    .wbs_we_o     (wbs_we),
    .wbs_sel_o    (wbs_sel),
    .wbs_adr_o    (wbs_adr),
    .wbs_dat_o    (wbs_dat_w),
    .wbs_ack_i    (wbs_ack),
    .wbs_dat_i    (wbs_dat_r)
  );

  t05_wb_memory #(.BASE(HIST_BASE), .SEED(RNG_SEED)) u_mem (
    .hwclk    (hwclk),
    .rst_n_i  (rst_n_i),
    .wbs_cyc_i(wbs_cyc),
    .wbs_stb_i(wbs_stb),
    .wbs_we_i (wbs_we),
    .wbs_sel_i(wbs_sel),
    .wbs_adr_i(wbs_adr),
    .wbs_dat_i(wbs_dat_w),
    .wbs_ack_o(wbs_ack),
    .wbs_dat_o(wbs_dat_r)
  );

  initial begin
    hwclk = 1'b0;
    forever #HALF_PERIOD hwclk = ~hwclk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("Error at %0d ns: %s", $time, msg);
  endtask

  task automatic add_text(input string s);
    int i;
    for (i = 0; i < s.len(); i++) begin
      char_q.push_back(s[i]);
    end
  endtask

  // characters go out LSB first and the last chunk is padded with random bits
  task automatic pack_run(input int r);
    logic [15:0] acc;
    int          nbits;
    int          i;
    run_first[r] = chunk_mem.size();
    acc = '0;
    nbits = 0;
    for (i = 0; i < char_q.size(); i++) begin
      acc = acc | (16'(char_q[i]) << nbits);
      nbits += 8;
      while (nbits >= 7) begin
        chunk_mem.push_back(acc[6:0]);
        acc = acc >> 7;
        nbits -= 7;
      end
    end
    if (nbits > 0) begin
      rng = xorshift32(rng);
      acc = acc | (16'(rng[6:0]) << nbits);
      chunk_mem.push_back(acc[6:0]);
    end
    run_len[r] = chunk_mem.size() - run_first[r];
  endtask

  task automatic build_streams();
    int i;
    // a and b tie at 2 and c is the rarest
    char_q.delete();
    add_text("abcab");
    char_q.push_back(t05_pkg::EOF_CHAR);
    add_text("zz");
    pack_run(0);
    // one distinct character only
    char_q.delete();
    add_text("qqqq");
    char_q.push_back(t05_pkg::EOF_CHAR);
    add_text("r");
    pack_run(1);
    // any byte value with mostly single hits
    char_q.delete();
    for (i = 0; i < 40; i++) begin
      rng = xorshift32(rng);
      char_q.push_back(rng[7:0]);
    end
    char_q.push_back(t05_pkg::EOF_CHAR);
    char_q.push_back(8'h55);
    pack_run(2);
    // small alphabet with larger counts
    char_q.delete();
    for (i = 0; i < 60; i++) begin
      rng = xorshift32(rng);
      char_q.push_back(8'h61 + 8'(rng[2:0]));
    end
    char_q.push_back(t05_pkg::EOF_CHAR);
    pack_run(3);
  endtask

  // repack chunks and count up to the first EOF before picking the two least
  function automatic t05_pkg::flv_result_t predict_run(input int first, input int len);
    logic [15:0]          acc;
    int                   nbits;
    int                   i;
    int                   c;
    logic                 found_eof;
    t05_pkg::char_t       ch;
    t05_pkg::flv_result_t res;
    for (c = 0; c < 256; c++) begin
      exp_count[c] = '0;
    end
    exp_total = '0;
    n_drive = len;
    acc = '0;
    nbits = 0;
    found_eof = 1'b0;
    for (i = 0; i < len && !found_eof; i++) begin
      acc = acc | (16'(chunk_mem[first + i]) << nbits);
      nbits += 7;
      if (nbits >= 8) begin
        ch = acc[7:0];
        acc = acc >> 8;
        nbits -= 8;
        if (ch == t05_pkg::EOF_CHAR) begin
          found_eof = 1'b1;
          n_drive = i + 1;
        end else begin
          exp_count[ch]++;
          exp_total++;
        end
      end
    end
    res = '0;
    // strict compare in ascending order keeps the lower index on ties
    for (c = 0; c < 256; c++) begin
      if (exp_count[c] != 0 && (res.cnt1 == 0 || exp_count[c] < res.cnt1)) begin
        res.idx1 = 8'(c);
        res.cnt1 = exp_count[c];
      end
    end
    for (c = 0; c < 256; c++) begin
      if (exp_count[c] != 0 && !(res.cnt1 != 0 && 8'(c) == res.idx1) &&
          (res.cnt2 == 0 || exp_count[c] < res.cnt2)) begin
        res.idx2 = 8'(c);
        res.cnt2 = exp_count[c];
      end
    end
    return res;
  endfunction

  task automatic check_idle_outputs();
    int i;
    for (i = 0; i < 4; i++) begin
      @(negedge hwclk);
      checks++;
      assert (!wbs_cyc && !wbs_stb && !wbs_we && !done_o && !char_ready_o) else
        report_error($sformatf("outputs active before start cyc=%b stb=%b we=%b done=%b ready=%b",
                               wbs_cyc, wbs_stb, wbs_we, done_o, char_ready_o));
    end
  endtask

  task automatic send_chunk(input t05_pkg::chunk_t c);
    @(negedge hwclk);
    while (!char_ready_o) begin
      @(negedge hwclk);
    end
    @(posedge hwclk);
    chunk_pulse_i <= 1'b1;
    chunk_i       <= c;
    @(posedge hwclk);
    chunk_pulse_i <= 1'b0;
    // a completed byte reaches the holder one edge later
    @(posedge hwclk);
  endtask

  initial begin : stimulus
    int r;
    int i;
    rst_n_i       = 1'b0;
    start_i       = 1'b0;
    chunk_pulse_i = 1'b0;
    chunk_i       = '0;
    rng           = RNG_SEED;
    checks        = 0;
    errors        = 0;
    runs_checked  = 0;
    streams_ready = 1'b0;
    build_streams();
    streams_ready = 1'b1;
    repeat (2) @(posedge hwclk);
    rst_n_i <= 1'b1;
    check_idle_outputs();
    for (r = 0; r < NUM_RUNS; r++) begin
      exp_result = predict_run(run_first[r], run_len[r]);
      @(posedge hwclk);
      start_i <= 1'b1;
      @(posedge hwclk);
      start_i <= 1'b0;
      for (i = 0; i < n_drive; i++) begin
        send_chunk(chunk_mem[run_first[r] + i]);
      end
      wait (runs_checked == r + 1);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin : compare_results
    int r;
    int c;
    for (r = 0; r < NUM_RUNS; r++) begin
      @(posedge done_o);
      @(negedge hwclk);
      checks++;
      assert (total_o == exp_total) else
        report_error($sformatf("run %0d total_o %0d, expected %0d", r, total_o, exp_total));
      checks++;
      assert (result_o.idx1 == exp_result.idx1 && result_o.cnt1 == exp_result.cnt1) else
        report_error($sformatf("run %0d least idx %02h cnt %0d, expected idx %02h cnt %0d",
                               r, result_o.idx1, result_o.cnt1,
                               exp_result.idx1, exp_result.cnt1));
      checks++;
      assert (result_o.idx2 == exp_result.idx2 && result_o.cnt2 == exp_result.cnt2) else
        report_error($sformatf("run %0d second idx %02h cnt %0d, expected idx %02h cnt %0d",
                               r, result_o.idx2, result_o.cnt2,
                               exp_result.idx2, exp_result.cnt2));
      // garbage or old counts must all be gone
      for (c = 0; c < 256; c++) begin
        checks++;
        assert (u_mem.mem[c] == exp_count[c]) else
          report_error($sformatf("run %0d counter %02h holds %0d, expected %0d",
                                 r, c, u_mem.mem[c], exp_count[c]));
      end
      runs_checked = r + 1;
    end
  end

  initial begin : watchdog
    int limit;
    wait (streams_ready);
    limit = 400 * chunk_mem.size() + 2000 * NUM_RUNS;
    repeat (limit) @(posedge hwclk);
    $display("timeout: the runs did not finish within %0d clock cycles", limit);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- t05_wb_memory.sv
module t05_wb_memory #(
  parameter t05_pkg::wb_addr_t BASE = 32'h3300_0000,
  parameter logic [31:0]       SEED = 32'h0000_0001
) (
  input  logic              hwclk,
  input  logic              rst_n_i,
  input  logic              wbs_cyc_i,
  input  logic              wbs_stb_i,
  input  logic              wbs_we_i,
  input  logic [3:0]        wbs_sel_i,
  input  t05_pkg::wb_addr_t wbs_adr_i,
  input  t05_pkg::count_t   wbs_dat_i,
  output logic              wbs_ack_o,
  output t05_pkg::count_t   wbs_dat_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // counter table, read directly by the testbench
  t05_pkg::count_t mem [256];

  logic [31:0] rng;
  logic        pending_q;
  logic [1:0]  wait_q;
  logic [1:0]  wait_v;
  logic [7:0]  word_idx;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  assign word_idx = 8'((wbs_adr_i - BASE) >> 2);

  // nonzero garbage, different for every word
  initial begin : preload
    int i;
    for (i = 0; i < 256; i++) begin
      mem[i] = {8'hA5, 8'(i), ~8'(i), 8'h3C};
    end
  end

  // 0 to 3 wait cycles drawn per transfer
  always @(posedge hwclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wbs_ack_o <= 1'b0;
      pending_q <= 1'b0;
      wait_q    <= '0;
      rng = SEED;
    end else begin
      wbs_ack_o <= 1'b0;
      if (wbs_cyc_i && wbs_stb_i && !wbs_ack_o) begin
        if (pending_q) begin
          wait_v = wait_q;
        end else begin
          rng = xorshift32(rng);
          wait_v = rng[1:0];
        end
        if (wait_v == 2'd0) begin
          wbs_ack_o <= 1'b1;
          pending_q <= 1'b0;
          if (wbs_we_i && wbs_sel_i == 4'hF) begin
            mem[word_idx] <= wbs_dat_i;
          end else if (!wbs_we_i) begin
            wbs_dat_o <= mem[word_idx];
          end
        end else begin
          pending_q <= 1'b1;
          wait_q    <= wait_v - 2'd1;
        end
      end
    end
  end

endmodule

//--- t05_top.sv
module t05_top #(
  parameter t05_pkg::wb_addr_t HIST_BASE = 32'h3300_0000
) (
  input  logic                  hwclk,
  input  logic                  rst_n_i,
  input  logic                  start_i,
  input  logic                  chunk_pulse_i,
  input  t05_pkg::chunk_t       chunk_i,
  output logic                  char_ready_o,
  output logic                  done_o,
  output t05_pkg::count_t       total_o,
  output t05_pkg::flv_result_t  result_o,
  output logic                  wbs_cyc_o,
  output logic                  wbs_stb_o,
  output logic                  wbs_we_o,
  output logic [3:0]            wbs_sel_o,
  output t05_pkg::wb_addr_t     wbs_adr_o,
  output t05_pkg::count_t       wbs_dat_o,
  input  logic                  wbs_ack_i,
  input  t05_pkg::count_t       wbs_dat_i
);

  logic               byte_valid;
  t05_pkg::char_t     byte_val;
  logic               flush;
  logic               clear_fin;
  logic               count_fin;
  logic               scan_fin;
  t05_pkg::phase_t    phase;
  t05_pkg::bus_req_t  hist_req;
  t05_pkg::bus_req_t  flv_req;
  t05_pkg::bus_req_t  bus_req;
  t05_pkg::bus_rsp_t  bus_rsp;

  t05_bytecount u_bytecount (
    .hwclk        (hwclk),
    .rst_n_i      (rst_n_i),
    .chunk_pulse_i(chunk_pulse_i),
    .chunk_i      (chunk_i),
    .flush_i      (flush),
    .byte_valid_o (byte_valid),
    .byte_o       (byte_val)
  );

  t05_histogram #(.HIST_BASE(HIST_BASE)) u_histogram (
    .hwclk       (hwclk),
    .rst_n_i     (rst_n_i),
    .phase_i     (phase),
    .byte_valid_i(byte_valid),
    .byte_i      (byte_val),
    .char_ready_o(char_ready_o),
    .rsp_i       (bus_rsp),
    .req_o       (hist_req),
    .total_o     (total_o),
    .clear_fin_o (clear_fin),
    .count_fin_o (count_fin),
    .flush_o     (flush)
  );

  t05_find_least #(.HIST_BASE(HIST_BASE)) u_find_least (
    .hwclk     (hwclk),
    .rst_n_i   (rst_n_i),
    .phase_i   (phase),
    .rsp_i     (bus_rsp),
    .req_o     (flv_req),
    .result_o  (result_o),
    .scan_fin_o(scan_fin)
  );

  t05_controller u_controller (
    .hwclk      (hwclk),
    .rst_n_i    (rst_n_i),
    .start_i    (start_i),
    .clear_fin_i(clear_fin),
    .count_fin_i(count_fin),
    .scan_fin_i (scan_fin),
    .hist_req_i (hist_req),
    .flv_req_i  (flv_req),
    .req_o      (bus_req),
    .phase_o    (phase),
    .done_o     (done_o)
  );

  // response fans out to every block
  t05_wishbone_manager u_wb_manager (
    .hwclk    (hwclk),
    .rst_n_i  (rst_n_i),
    .req_i    (bus_req),
    .rsp_o    (bus_rsp),
    .wbs_cyc_o(wbs_cyc_o),
    .wbs_stb_o(wbs_stb_o),
    .wbs_we_o (wbs_we_o),
    .wbs_sel_o(wbs_sel_o),
    .wbs_adr_o(wbs_adr_o),
    .wbs_dat_o(wbs_dat_o),
    .wbs_ack_i(wbs_ack_i),
    .wbs_dat_i(wbs_dat_i)
  );

endmodule

//--- t05_controller.sv
module t05_controller (
  input  logic               hwclk,
  input  logic               rst_n_i,
  input  logic               start_i,
  input  logic               clear_fin_i,
  input  logic               count_fin_i,
  input  logic               scan_fin_i,
  input  t05_pkg::bus_req_t  hist_req_i,
  input  t05_pkg::bus_req_t  flv_req_i,
  output t05_pkg::bus_req_t  req_o,
  output t05_pkg::phase_t    phase_o,
  output logic               done_o
);

  t05_pkg::phase_t state_q;
  t05_pkg::phase_t state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      t05_pkg::PH_IDLE: begin
        if (start_i) begin
          state_d = t05_pkg::PH_CLEAR;
        end
      end
      t05_pkg::PH_CLEAR: begin
        if (clear_fin_i) begin
          state_d = t05_pkg::PH_COUNT;
        end
      end
      t05_pkg::PH_COUNT: begin
        if (count_fin_i) begin
          state_d = t05_pkg::PH_SCAN;
        end
      end
      t05_pkg::PH_SCAN: begin
        if (scan_fin_i) begin
          state_d = t05_pkg::PH_DONE;
        end
      end
      t05_pkg::PH_DONE: begin
        // a new start reruns everything from the clear
        if (start_i) begin
          state_d = t05_pkg::PH_CLEAR;
        end
      end
      default: state_d = t05_pkg::PH_IDLE;
    endcase
  end

  always_ff @(posedge hwclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= t05_pkg::PH_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // bus goes to whichever block owns the phase
  always_comb begin
    req_o = '0;
    case (state_q)
      t05_pkg::PH_CLEAR, t05_pkg::PH_COUNT: req_o = hist_req_i;
      t05_pkg::PH_SCAN:                     req_o = flv_req_i;
      default:                              req_o = '0;
    endcase
  end

  assign phase_o = state_q;
  assign done_o  = (state_q == t05_pkg::PH_DONE);

endmodule

//--- t05_wishbone_manager.sv
module t05_wishbone_manager (
  input  logic               hwclk,
  input  logic               rst_n_i,
  input  t05_pkg::bus_req_t  req_i,
  output t05_pkg::bus_rsp_t  rsp_o,
  output logic               wbs_cyc_o,
  output logic               wbs_stb_o,
  output logic               wbs_we_o,
  output logic [3:0]         wbs_sel_o,
  output t05_pkg::wb_addr_t  wbs_adr_o,
  output t05_pkg::count_t    wbs_dat_o,
  input  logic               wbs_ack_i,
  input  t05_pkg::count_t    wbs_dat_i
);

  typedef enum logic {
    M_IDLE,
    M_ACTIVE
  } mgr_state_t;

  mgr_state_t         state_q;
  logic               we_q;
  logic               done_q;
  logic               start;
  t05_pkg::wb_addr_t  adr_q;
  t05_pkg::count_t    dat_q;
  t05_pkg::count_t    rdata_q;

  // strobes seen while a cycle is open are ignored
  assign start = (state_q == M_IDLE) && (req_i.read || req_i.write);

  always_ff @(posedge hwclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= M_IDLE;
      we_q    <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start) begin
        state_q <= M_ACTIVE;
        we_q    <= req_i.write;
      end else if (state_q == M_ACTIVE && wbs_ack_i) begin
        state_q <= M_IDLE;
        we_q    <= 1'b0;
        done_q  <= 1'b1;
      end
    end
  end

  always_ff @(posedge hwclk) begin
    if (start) begin
      adr_q <= req_i.addr;
      dat_q <= req_i.wdata;
    end
    if (state_q == M_ACTIVE && wbs_ack_i && !we_q) begin
      rdata_q <= wbs_dat_i;
    end
  end

  assign wbs_cyc_o = (state_q == M_ACTIVE);
  assign wbs_stb_o = (state_q == M_ACTIVE);
  assign wbs_we_o  = we_q;
  assign wbs_sel_o = 4'hF;
  assign wbs_adr_o = adr_q;
  assign wbs_dat_o = dat_q;

  // busy covers the strobe cycle through the done cycle
  always_comb begin
    rsp_o.rdata = rdata_q;
    rsp_o.done  = done_q;
    rsp_o.busy  = req_i.read || req_i.write || (state_q == M_ACTIVE) || done_q;
  end

endmodule

//--- t05_find_least.sv
module t05_find_least #(
  parameter t05_pkg::wb_addr_t HIST_BASE = 32'h3300_0000
) (
  input  logic                  hwclk,
  input  logic                  rst_n_i,
  input  t05_pkg::phase_t       phase_i,
  input  t05_pkg::bus_rsp_t     rsp_i,
  output t05_pkg::bus_req_t     req_o,
  output t05_pkg::flv_result_t  result_o,
  output logic                  scan_fin_o
);

  typedef enum logic [1:0] {
    F_IDLE,
    F_REQ,
    F_WAIT,
    F_FIN
  } flv_state_t;

  flv_state_t         state_q;
  t05_pkg::char_t     idx_q;
  logic               rd_q;
  t05_pkg::wb_addr_t  addr_q;
  t05_pkg::count_t    val;
  logic               take1;
  logic               take2;

  // a zero count in a slot means the slot is empty
  always_comb begin
    val   = rsp_i.rdata;
    take1 = (val != '0) && ((result_o.cnt1 == '0) || (val < result_o.cnt1));
    take2 = (val != '0) && !take1 &&
            ((result_o.cnt2 == '0) || (val < result_o.cnt2));
  end

  always_comb begin
    req_o.read  = rd_q;
    req_o.write = 1'b0;
    req_o.addr  = addr_q;
    req_o.wdata = '0;
  end

  always_ff @(posedge hwclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= F_IDLE;
      idx_q      <= '0;
      rd_q       <= 1'b0;
      addr_q     <= '0;
      result_o   <= '0;
      scan_fin_o <= 1'b0;
    end else begin
      rd_q       <= 1'b0;
      scan_fin_o <= 1'b0;
      case (state_q)
        F_IDLE: begin
          if (phase_i == t05_pkg::PH_SCAN) begin
            idx_q    <= '0;
            result_o <= '0;
            state_q  <= F_REQ;
          end
        end
        F_REQ: begin
          if (!rsp_i.busy) begin
            rd_q    <= 1'b1;
            addr_q  <= HIST_BASE + (t05_pkg::wb_addr_t'(idx_q) << 2);
            state_q <= F_WAIT;
          end
        end
        F_WAIT: begin
          if (rsp_i.done) begin
            // ties keep the earlier, lower index
            if (take1) begin
              result_o.idx2 <= result_o.idx1;
              result_o.cnt2 <= result_o.cnt1;
              result_o.idx1 <= idx_q;
              result_o.cnt1 <= val;
            end else if (take2) begin
              result_o.idx2 <= idx_q;
              result_o.cnt2 <= val;
            end
            if (idx_q == 8'hFF) begin
              scan_fin_o <= 1'b1;
              state_q    <= F_FIN;
            end else begin
              idx_q   <= idx_q + 1'b1;
              state_q <= F_REQ;
            end
          end
        end
        F_FIN: begin
          if (phase_i != t05_pkg::PH_SCAN) begin
            state_q <= F_IDLE;
          end
        end
        default: state_q <= F_IDLE;
      endcase
    end
  end

endmodule

//--- t05_histogram.sv
module t05_histogram #(
  parameter t05_pkg::wb_addr_t HIST_BASE = 32'h3300_0000
) (
  input  logic               hwclk,
  input  logic               rst_n_i,
  input  t05_pkg::phase_t    phase_i,
  input  logic               byte_valid_i,
  input  t05_pkg::char_t     byte_i,
  output logic               char_ready_o,
  input  t05_pkg::bus_rsp_t  rsp_i,
  output t05_pkg::bus_req_t  req_o,
  output t05_pkg::count_t    total_o,
  output logic               clear_fin_o,
  output logic               count_fin_o,
  output logic               flush_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_CLR_REQ,
    S_CLR_WAIT,
    S_CNT_IDLE,
    S_RD_WAIT,
    S_WR_REQ,
    S_WR_WAIT
  } hist_state_t;

  hist_state_t        state_q;
  t05_pkg::char_t     idx_q;
  t05_pkg::char_t     hold_q;
  logic               full_q;
  logic               rd_q;
  logic               wr_q;
  t05_pkg::wb_addr_t  addr_q;
  t05_pkg::count_t    wdata_q;

  assign char_ready_o = (phase_i == t05_pkg::PH_COUNT) && !full_q;

  always_comb begin
    req_o.read  = rd_q;
    req_o.write = wr_q;
    req_o.addr  = addr_q;
    req_o.wdata = wdata_q;
  end

  always_ff @(posedge hwclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= S_IDLE;
      idx_q       <= '0;
      hold_q      <= '0;
      full_q      <= 1'b0;
      rd_q        <= 1'b0;
      wr_q        <= 1'b0;
      addr_q      <= '0;
      wdata_q     <= '0;
      total_o     <= '0;
      clear_fin_o <= 1'b0;
      count_fin_o <= 1'b0;
      flush_o     <= 1'b0;
    end else begin
      rd_q        <= 1'b0;
      wr_q        <= 1'b0;
      clear_fin_o <= 1'b0;
      count_fin_o <= 1'b0;
      flush_o     <= 1'b0;

      // single-entry holder, EOF never enters it
      if (char_ready_o && byte_valid_i) begin
        if (byte_i == t05_pkg::EOF_CHAR) begin
          count_fin_o <= 1'b1;
          flush_o     <= 1'b1;
        end else begin
          hold_q <= byte_i;
          full_q <= 1'b1;
        end
      end

      case (state_q)
        S_IDLE: begin
          if (phase_i == t05_pkg::PH_CLEAR) begin
            idx_q   <= '0;
            total_o <= '0;
            full_q  <= 1'b0;
            flush_o <= 1'b1;
            state_q <= S_CLR_REQ;
          end
        end
        S_CLR_REQ: begin
          if (!rsp_i.busy) begin
            wr_q    <= 1'b1;
            addr_q  <= HIST_BASE + (t05_pkg::wb_addr_t'(idx_q) << 2);
            wdata_q <= '0;
            state_q <= S_CLR_WAIT;
          end
        end
        S_CLR_WAIT: begin
          if (rsp_i.done) begin
            if (idx_q == 8'hFF) begin
              clear_fin_o <= 1'b1;
              state_q     <= S_CNT_IDLE;
            end else begin
              idx_q   <= idx_q + 1'b1;
              state_q <= S_CLR_REQ;
            end
          end
        end
        S_CNT_IDLE: begin
          if (phase_i == t05_pkg::PH_COUNT && full_q && !rsp_i.busy) begin
            rd_q    <= 1'b1;
            addr_q  <= HIST_BASE + (t05_pkg::wb_addr_t'(hold_q) << 2);
            state_q <= S_RD_WAIT;
          end else if (phase_i != t05_pkg::PH_CLEAR && phase_i != t05_pkg::PH_COUNT) begin
            state_q <= S_IDLE;
          end
        end
        S_RD_WAIT: begin
          if (rsp_i.done) begin
            wdata_q <= rsp_i.rdata + 1'b1;
            state_q <= S_WR_REQ;
          end
        end
        S_WR_REQ: begin
          // same address as the read
          if (!rsp_i.busy) begin
            wr_q    <= 1'b1;
            state_q <= S_WR_WAIT;
          end
        end
        S_WR_WAIT: begin
          if (rsp_i.done) begin
            full_q  <= 1'b0;
            total_o <= total_o + 1'b1;
            state_q <= S_CNT_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

endmodule

//--- t05_bytecount.sv
module t05_bytecount (
  input  logic            hwclk,
  input  logic            rst_n_i,
  input  logic            chunk_pulse_i,
  input  t05_pkg::chunk_t chunk_i,
  input  logic            flush_i,
  output logic            byte_valid_o,
  output t05_pkg::char_t  byte_o
);

  // leftover bits, right aligned, bits above cnt_q stay zero
  logic [6:0]  acc_q;
  logic [2:0]  cnt_q;
  logic [13:0] merged;
  logic [3:0]  total_bits;

  // new chunk goes on top of the leftover bits
  always_comb begin
    merged     = {7'b0, acc_q} | ({7'b0, chunk_i} << cnt_q);
    total_bits = {1'b0, cnt_q} + 4'd7;
  end

  always_ff @(posedge hwclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q        <= '0;
      cnt_q        <= '0;
      byte_valid_o <= 1'b0;
    end else begin
      byte_valid_o <= 1'b0;
      if (flush_i) begin
        acc_q <= '0;
        cnt_q <= '0;
      end else if (chunk_pulse_i) begin
        // total_bits[2:0] is the leftover count either way
        cnt_q <= total_bits[2:0];
        if (total_bits[3]) begin
          byte_valid_o <= 1'b1;
          acc_q        <= {1'b0, merged[13:8]};
        end else begin
          acc_q <= merged[6:0];
        end
      end
    end
  end

  always_ff @(posedge hwclk) begin
    if (chunk_pulse_i && !flush_i && total_bits[3]) begin
      byte_o <= merged[7:0];
    end
  end

endmodule

//--- t05_pkg.sv
package t05_pkg;

  // widths with a meaning of their own
  typedef logic [7:0]  char_t;
  typedef logic [6:0]  chunk_t;
  typedef logic [31:0] count_t;
  typedef logic [31:0] wb_addr_t;

  // top level phases, in the order the controller walks them
  typedef enum logic [2:0] {
    PH_IDLE,
    PH_CLEAR,
    PH_COUNT,
    PH_SCAN,
    PH_DONE
  } phase_t;

  // request from a block to the bus manager
  typedef struct packed {
    logic     read;
    logic     write;
    wb_addr_t addr;
    count_t   wdata;
  } bus_req_t;

  // response shared by all requesters
  typedef struct packed {
    count_t rdata;
    logic   done;
    logic   busy;
  } bus_rsp_t;

  // two least frequent characters, cnt1 <= cnt2
  typedef struct packed {
    char_t  idx1;
    count_t cnt1;
    char_t  idx2;
    count_t cnt2;
  } flv_result_t;

  localparam char_t EOF_CHAR = 8'h1A;

endpackage
